/* hdl/sw_cfg.svh */
// Smith-Waterman array configuration: score width, array length and biased zero
`ifndef SW_CFG_SVH
`define SW_CFG_SVH

// ======================================================================
// score format
// ======================================================================

// bits per score word
`define SW_SCORE_WIDTH 12

// scores are stored biased, true value plus SW_ZERO
// gives 2^(SW_SCORE_WIDTH-1) sized to one score word
`define SW_ZERO {1'b1, {(`SW_SCORE_WIDTH - 1){1'b0}}}

// ======================================================================
// array size
// ======================================================================

// one PE per query base, so this is the longest query
`define SW_NUM_PE 8

`endif

/* hdl/sw_pkg.sv */
// Smith-Waterman shared types: nucleotide codes, biased score word, stage state
`include "sw_cfg.svh"

package sw_pkg;

	// ==================================================================
	// nucleotide encoding
	// ==================================================================
	typedef enum logic [1:0] {
		A = 2'b00,                        // adenine
		G = 2'b01,                        // guanine
		T = 2'b10,                        // thymine
		C = 2'b11                         // cytosine
	} base_t;

	// ==================================================================
	// score word
	// ==================================================================
	// biased for matrix values, two's complement for penalties
	typedef logic [`SW_SCORE_WIDTH-1:0] score_t;

	// ==================================================================
	// per-stage control state
	// ==================================================================
	typedef enum logic {
		IDLE = 1'b0,                      // between bursts
		CALC = 1'b1                       // burst in progress
	} pe_state_t;

endpackage

/* hdl/sw_score_stage1.sv */
// PE score stage 1: diagonal hold, match/mismatch select and gap sums
`timescale 1ns/1ns
`include "sw_cfg.svh"

module sw_score_stage1 (
	input  logic           clk,
	input  logic           rst,          // sync, active low
	input  logic           en_in,        // target beat valid
	input  sw_pkg::base_t  target_in,    // target base from left PE
	input  sw_pkg::base_t  query_base,   // query base held by this PE
	input  sw_pkg::score_t m_in,         // M from left PE, same target base
	input  sw_pkg::score_t i_in,         // I from left PE, same target base
	input  sw_pkg::score_t m_up,         // own M of the previous beat
	input  sw_pkg::score_t i_up,         // own I of the previous beat
	input  sw_pkg::score_t match,        // two's complement penalties
	input  sw_pkg::score_t mismatch,
	input  sw_pkg::score_t gap_open,
	input  sw_pkg::score_t gap_extend,
	output logic           en_s,         // enable into stage 2
	output sw_pkg::base_t  target_s,
	output sw_pkg::score_t sub_r,        // chosen substitution score
	output sw_pkg::score_t diag_max_r,   // max of diagonal M and I
	output sw_pkg::score_t m_open_r,     // gap-open candidate
	output sw_pkg::score_t i_extend_r    // gap-extend candidate
);

	sw_pkg::pe_state_t state;            // IDLE until first beat of a burst
	sw_pkg::score_t    m_diag;           // left M of the previous beat
	sw_pkg::score_t    i_diag;           // left I of the previous beat
	sw_pkg::score_t    sub;
	sw_pkg::score_t    diag_max;
	sw_pkg::score_t    m_max;
	sw_pkg::score_t    i_max;

	// ==================================================================
	// combinational part
	// ==================================================================
	always_comb
	begin
		sub = (target_in == query_base) ? match : mismatch;
		if (state == sw_pkg::CALC)
		begin
			diag_max = (m_diag > i_diag) ? m_diag : i_diag;
			m_max    = (m_in > m_up) ? m_in : m_up;
			i_max    = (i_in > i_up) ? i_in : i_up;
		end
		else
		begin
			// first beat, row above the matrix is zero
			diag_max = `SW_ZERO;
			m_max    = (m_in > `SW_ZERO) ? m_in : `SW_ZERO;
			i_max    = (i_in > `SW_ZERO) ? i_in : `SW_ZERO;
		end
	end

	// ==================================================================
	// sequential part
	// ==================================================================
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state      <= sw_pkg::IDLE;
			en_s       <= 1'b0;
			target_s   <= sw_pkg::A;
			sub_r      <= '0;
			diag_max_r <= `SW_ZERO;
			m_open_r   <= `SW_ZERO;
			i_extend_r <= `SW_ZERO;
		end
		else
		begin
			case (state)
				sw_pkg::IDLE: if (en_in) state <= sw_pkg::CALC;   // burst starts
				sw_pkg::CALC: if (!en_in) state <= sw_pkg::IDLE;  // burst done
			endcase
			en_s <= en_in;
			if (en_in)
			begin
				target_s   <= target_in;
				sub_r      <= sub;
				diag_max_r <= diag_max;
				m_open_r   <= m_max + gap_open + gap_extend;  // open costs both
				i_extend_r <= i_max + gap_extend;
			end
			else
			begin
				sub_r      <= '0;
				diag_max_r <= `SW_ZERO;
				m_open_r   <= `SW_ZERO;
				i_extend_r <= `SW_ZERO;
			end
		end
	end

	// left scores become next beat's diagonal
	always_ff @(posedge clk)
	begin
		if (en_in)
		begin
			m_diag <= m_in;
			i_diag <= i_in;
		end
	end

endmodule

/* hdl/sw_score_stage2.sv */
// PE score stage 2: clamped match score, in-del score and outputs to next PE
`timescale 1ns/1ns
`include "sw_cfg.svh"

module sw_score_stage2 (
	input  logic           clk,
	input  logic           rst,          // sync, active low
	input  logic           en_s,         // enable from stage 1
	input  sw_pkg::base_t  target_s,
	input  sw_pkg::score_t sub_r,        // two's complement substitution
	input  sw_pkg::score_t diag_max_r,   // biased diagonal max
	input  sw_pkg::score_t m_open_r,
	input  sw_pkg::score_t i_extend_r,
	output logic           en_out,       // enable to right PE
	output sw_pkg::base_t  target_out,   // target base to right PE
	output sw_pkg::score_t m_out,        // M to right PE
	output sw_pkg::score_t i_out,        // I to right PE
	output sw_pkg::score_t m_next,       // M ahead of the register
	output sw_pkg::score_t i_next        // I ahead of the register
);

	sw_pkg::score_t m_sum;               // unclamped match score

	// ==================================================================
	// score buses
	// ==================================================================
	// m_next and i_next go back to stage 1 as the same-row values, so the
	// row recurrence closes within one beat at full rate
	always_comb
	begin
		m_sum  = diag_max_r + sub_r;
		m_next = (m_sum >= `SW_ZERO) ? m_sum : `SW_ZERO;     // local clamp
		i_next = (m_open_r > i_extend_r) ? m_open_r : i_extend_r;
	end

	// ==================================================================
	// output registers
	// ==================================================================
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			en_out     <= 1'b0;
			target_out <= sw_pkg::A;
			m_out      <= `SW_ZERO;
			i_out      <= `SW_ZERO;
		end
		else
		begin
			en_out <= en_s;
			if (en_s)
			begin
				target_out <= target_s;
				m_out      <= m_next;
				i_out      <= i_next;
			end
			else
			begin
				m_out <= `SW_ZERO;                           // idle scores
				i_out <= `SW_ZERO;
			end
		end
	end

endmodule

/* hdl/sw_high_score.sv */
// PE stage 3: running high score along the chain and end-of-burst valid
`timescale 1ns/1ns
`include "sw_cfg.svh"

module sw_high_score (
	input  logic           clk,
	input  logic           rst,          // sync, active low
	input  logic           en_out,       // stage 2 enable
	input  sw_pkg::score_t m_out,        // this PE's M
	input  sw_pkg::score_t i_out,        // this PE's I
	input  sw_pkg::score_t high_in,      // high score from left PE
	output sw_pkg::score_t high_out,     // high score to right PE
	output logic           vld           // burst result ready
);

	sw_pkg::pe_state_t state;
	sw_pkg::score_t    cell_max;         // max(M, I) of this cell
	sw_pkg::score_t    run_max;          // left high or own running high
	sw_pkg::score_t    high_next;

	always_comb
	begin
		cell_max = (m_out > i_out) ? m_out : i_out;
		// own history counts only once the burst has started here
		if ((state == sw_pkg::CALC) && (high_out > high_in))
			run_max = high_out;
		else
			run_max = high_in;
		high_next = (run_max > cell_max) ? run_max : cell_max;
	end

	// ==================================================================
	// high score FSM
	// ==================================================================
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state    <= sw_pkg::IDLE;
			vld      <= 1'b0;
			high_out <= `SW_ZERO;
		end
		else
		begin
			case (state)
				sw_pkg::IDLE:
				begin
					vld <= 1'b0;
					if (en_out)
					begin
						high_out <= high_next;           // first beat
						state    <= sw_pkg::CALC;
					end
					else
						high_out <= `SW_ZERO;            // clear between bursts
				end
				sw_pkg::CALC:
				begin
					if (en_out)
						high_out <= high_next;           // keep collecting
					else
					begin
						vld   <= 1'b1;                   // hold result one cycle
						state <= sw_pkg::IDLE;
					end
				end
			endcase
		end
	end

endmodule

/* hdl/sw_pe.sv */
// Smith-Waterman processing element: one query base, three pipeline stages
`timescale 1ns/1ns

module sw_pe (
	input  logic           clk,
	input  logic           rst,          // sync, active low
	input  logic           en_in,
	input  sw_pkg::base_t  target_in,
	input  sw_pkg::base_t  query_base,
	input  sw_pkg::score_t m_in,
	input  sw_pkg::score_t i_in,
	input  sw_pkg::score_t high_in,
	input  sw_pkg::score_t match,
	input  sw_pkg::score_t mismatch,
	input  sw_pkg::score_t gap_open,
	input  sw_pkg::score_t gap_extend,
	output logic           en_out,
	output sw_pkg::base_t  target_out,
	output sw_pkg::score_t m_out,
	output sw_pkg::score_t i_out,
	output sw_pkg::score_t high_out,
	output logic           vld
);

	logic           en_s;
	sw_pkg::base_t  target_s;
	sw_pkg::score_t sub_r;
	sw_pkg::score_t diag_max_r;
	sw_pkg::score_t m_open_r;
	sw_pkg::score_t i_extend_r;
	sw_pkg::score_t m_fwd;               // same-row M back to stage 1
	sw_pkg::score_t i_fwd;               // same-row I back to stage 1

	sw_score_stage1 stage1 (
		.clk(clk), .rst(rst), .en_in(en_in), .target_in(target_in),
		.query_base(query_base), .m_in(m_in), .i_in(i_in),
		.m_up(m_fwd), .i_up(i_fwd),
		.match(match), .mismatch(mismatch),
		.gap_open(gap_open), .gap_extend(gap_extend),
		.en_s(en_s), .target_s(target_s), .sub_r(sub_r),
		.diag_max_r(diag_max_r), .m_open_r(m_open_r), .i_extend_r(i_extend_r)
	);

	sw_score_stage2 stage2 (
		.clk(clk), .rst(rst), .en_s(en_s), .target_s(target_s),
		.sub_r(sub_r), .diag_max_r(diag_max_r),
		.m_open_r(m_open_r), .i_extend_r(i_extend_r),
		.en_out(en_out), .target_out(target_out),
		.m_out(m_out), .i_out(i_out), .m_next(m_fwd), .i_next(i_fwd)
	);

	sw_high_score stage3 (
		.clk(clk), .rst(rst), .en_out(en_out), .m_out(m_out), .i_out(i_out),
		.high_in(high_in), .high_out(high_out), .vld(vld)
	);

endmodule

/* hdl/sw_array.sv */
// Smith-Waterman systolic array: chain of PEs reporting each burst's best score
`timescale 1ns/1ns
`include "sw_cfg.svh"

module sw_array #(
	parameter int num_pe = `SW_NUM_PE   // query length, 1 or more
) (
	input  logic                        clk,
	input  logic                        rst,         // sync, active low
	input  logic                        en,          // high once per target base
	input  sw_pkg::base_t               target,      // target base stream
	input  sw_pkg::base_t [num_pe-1:0]  query,       // PE k takes query[k]
	input  sw_pkg::score_t              match,       // penalties, static per burst
	input  sw_pkg::score_t              mismatch,
	input  sw_pkg::score_t              gap_open,
	input  sw_pkg::score_t              gap_extend,
	output sw_pkg::score_t              high_score,  // biased best local score
	output logic                        vld          // one pulse per burst
);

	// ==================================================================
	// chain links, entry k feeds PE k
	// ==================================================================
	logic           en_c     [num_pe+1];
	sw_pkg::base_t  target_c [num_pe+1];
	sw_pkg::score_t m_c      [num_pe+1];
	sw_pkg::score_t i_c      [num_pe+1];
	sw_pkg::score_t high_c   [num_pe+1];
	logic           vld_c    [num_pe];  // only the last one leaves the array

	assign en_c[0]     = en;
	assign target_c[0] = target;
	assign m_c[0]      = `SW_ZERO;       // column left of the matrix
	assign i_c[0]      = `SW_ZERO;
	assign high_c[0]   = `SW_ZERO;

	for (genvar k = 0; k < num_pe; k++)
	begin : g_pe
		sw_pe pe (
			.clk(clk), .rst(rst), .en_in(en_c[k]), .target_in(target_c[k]),
			.query_base(query[k]), .m_in(m_c[k]), .i_in(i_c[k]),
			.high_in(high_c[k]), .match(match), .mismatch(mismatch),
			.gap_open(gap_open), .gap_extend(gap_extend),
			.en_out(en_c[k+1]), .target_out(target_c[k+1]),
			.m_out(m_c[k+1]), .i_out(i_c[k+1]),
			.high_out(high_c[k+1]), .vld(vld_c[k])
		);
	end

	assign high_score = high_c[num_pe];  // last PE holds the whole matrix max
	assign vld        = vld_c[num_pe-1];

endmodule

/* tests/sw_model.svh */
// Testbench reference model: affine-gap local alignment score and xorshift generator
`ifndef SW_MODEL_SVH
`define SW_MODEL_SVH

// 32-bit xorshift step, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic int max2(input int a, input int b);
	return (a > b) ? a : b;
endfunction

// ======================================================================
// best local score as a true value, no bias
// ======================================================================
// row i is query base i, column j is target base j
function automatic int best_local_score(input int qry[$], input int tgt[$],
	input int sc_match, input int sc_mismatch, input int sc_open, input int sc_extend);
	int m_tab [0:31][0:31];
	int i_tab [0:31][0:31];
	int m_diag, i_diag, m_left, i_left, m_up, i_up;
	int sub;
	int best;
	best = 0;                                            // local score never below zero
	for (int i = 0; i < qry.size(); i++)
	begin
		for (int j = 0; j < tgt.size(); j++)
		begin
			m_diag = 0;                                  // cells outside the matrix
			i_diag = 0;
			m_left = 0;
			i_left = 0;
			m_up   = 0;
			i_up   = 0;
			if (i > 0 && j > 0)
			begin
				m_diag = m_tab[i-1][j-1];
				i_diag = i_tab[i-1][j-1];
			end
			if (i > 0)
			begin
				m_left = m_tab[i-1][j];                  // previous query base
				i_left = i_tab[i-1][j];
			end
			if (j > 0)
			begin
				m_up = m_tab[i][j-1];                    // previous target base
				i_up = i_tab[i][j-1];
			end
			sub = (qry[i] == tgt[j]) ? sc_match : sc_mismatch;
			m_tab[i][j] = max2(0, sub + max2(m_diag, i_diag));
			i_tab[i][j] = max2(max2(m_left, m_up) + sc_open + sc_extend,
				max2(i_left, i_up) + sc_extend);
			best = max2(best, max2(m_tab[i][j], i_tab[i][j]));
		end
	end
	return best;
endfunction

`endif

/* tests/sw_tb.sv */
// Smith-Waterman array testbench: random and directed bursts against a reference model
`timescale 1ns/1ns
`include "sw_cfg.svh"

module sw_tb;

	localparam int num_pe      = `SW_NUM_PE;
	localparam int min_gap     = 2 * num_pe + 2;        // shortest idle time between bursts
	localparam int num_random  = 40;
	localparam int num_b2b     = 6;
	localparam int drain_max   = 4 * num_pe + 40;       // wait allowed for the last vld
	localparam int cycle_limit = (num_random + num_b2b + 10) * (17 + min_gap + 6)
		+ 6 * (drain_max + 2 * num_pe + 4) + 50;

	logic                       clk = 1'b0;
	logic                       rst;
	logic                       en;
	sw_pkg::base_t              target;
	sw_pkg::base_t [num_pe-1:0] query;
	sw_pkg::score_t             match;
	sw_pkg::score_t             mismatch;
	sw_pkg::score_t             gap_open;
	sw_pkg::score_t             gap_extend;
	sw_pkg::score_t             high_score;
	logic                       vld;

	logic [31:0]    rng_state = 32'hadfe;
	sw_pkg::score_t exp_q[$];                           // biased results still in flight
	string          name_q[$];
	int             qry[$];
	int             tgt[$];
	int             pen_match, pen_mismatch, pen_open, pen_extend;   // true values
	int             mismatch_count = 0;
	int             stray_count    = 0;                 // vld with nothing pending
	int             vld_count      = 0;
	int             fail_count     = 0;
	int             cycle_count    = 0;
	int             start_count;
	int             pos;
	sw_pkg::score_t got_exp;
	string          got_name;

	`include "sw_model.svh"

	sw_array #(.num_pe(num_pe)) dut0 (
		.clk(clk), .rst(rst), .en(en), .target(target), .query(query),
		.match(match), .mismatch(mismatch), .gap_open(gap_open), .gap_extend(gap_extend),
		.high_score(high_score), .vld(vld)
	);

	always #2 clk = ~clk;                               // 4 ns period

	function automatic int pick(input int lo, input int hi);
		rng_state = xorshift32(rng_state);
		return lo + int'(rng_state % 32'(hi - lo + 1));
	endfunction

	function automatic int model_score();
		return best_local_score(qry, tgt, pen_match, pen_mismatch, pen_open, pen_extend);
	endfunction

	// penalties kept inside limits so no score wraps
	task automatic random_setup(input int len);
		pen_match    = pick(1, 7);
		pen_mismatch = -pick(1, 7);
		pen_open     = -pick(1, 7);
		pen_extend   = -pick(1, 3);
		qry.delete();
		tgt.delete();
		for (int k = 0; k < num_pe; k++)
			qry.push_back(pick(0, 3));
		for (int j = 0; j < len; j++)
			tgt.push_back(pick(0, 3));
	endtask

	// first beat also applies this burst's query and penalties
	task automatic drive_beats(input int count);
		sw_pkg::base_t [num_pe-1:0] q_bits;
		for (int k = 0; k < num_pe; k++)
			q_bits[k] = sw_pkg::base_t'(2'(qry[k]));
		for (int j = 0; j < count; j++)
		begin
			@(posedge clk);
			if (j == 0)
			begin
				query      <= q_bits;
				match      <= sw_pkg::score_t'(pen_match);
				mismatch   <= sw_pkg::score_t'(pen_mismatch);
				gap_open   <= sw_pkg::score_t'(pen_open);
				gap_extend <= sw_pkg::score_t'(pen_extend);
			end
			en     <= 1'b1;
			target <= sw_pkg::base_t'(2'(tgt[j]));
		end
	endtask

	task automatic send_burst(input string name, input int score, input int gap);
		exp_q.push_back(sw_pkg::score_t'(score + 2 ** (`SW_SCORE_WIDTH - 1)));  // add bias
		name_q.push_back(name);
		drive_beats(tgt.size());
		@(posedge clk);
		en <= 1'b0;
		repeat (gap - 1) @(posedge clk);                // gap counts the falling cycle
	endtask

	task automatic wait_results();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < drain_max)
		begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			fail_count++;
			$display("no vld for %0d pending burst(s) after %0d cycles", exp_q.size(), waited);
			exp_q.delete();
			name_q.delete();
		end
		repeat (2 * num_pe + 4) @(posedge clk);         // room for a stray vld
	endtask

	// ======================================================================
	// result monitor, samples on the falling edge
	// ======================================================================
	always @(negedge clk)
	begin
		if (vld === 1'b1)
		begin
			vld_count++;
			if (exp_q.size() == 0)
			begin
				stray_count++;
				$display("vld raised at cycle %0d with no burst pending", cycle_count);
			end
			else
			begin
				got_exp  = exp_q.pop_front();
				got_name = name_q.pop_front();
				if (high_score !== got_exp)
				begin
					mismatch_count++;
					$display("mismatch %s: expected %0d actual %0d", got_name, got_exp, high_score);
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("run stopped at the %0d-cycle limit, %0d mismatches, %0d other errors",
				cycle_count, mismatch_count, stray_count + fail_count);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ======================================================================
	// test sequence
	// ======================================================================
	initial
	begin
		rst    = 1'b0;                                  // reset held for two cycles
		en     = 1'b0;
		target = sw_pkg::A;
		for (int k = 0; k < num_pe; k++)
			query[k] = sw_pkg::A;
		match      = '0;
		mismatch   = '0;
		gap_open   = '0;
		gap_extend = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);

		for (int b = 0; b < num_random; b++)
		begin
			random_setup(pick(1, 16));
			send_burst("random", model_score(), min_gap + pick(0, 6));
		end
		wait_results();

		random_setup(0);
		tgt = qry;                                      // full-length exact hit
		send_burst("identical", num_pe * pen_match, min_gap);
		wait_results();

		random_setup(0);
		qry.delete();
		for (int k = 0; k < num_pe; k++)
			qry.push_back(pick(0, 1));                  // A or G only
		repeat (pick(1, 16)) tgt.push_back(pick(2, 3)); // T or C only
		send_burst("all_mismatch", 0, min_gap);
		wait_results();

		start_count = vld_count;
		for (int b = 0; b < num_b2b; b++)
		begin
			random_setup(pick(1, 16));
			send_burst("back_to_back", model_score(), min_gap);
		end
		wait_results();
		if (vld_count - start_count != num_b2b)
		begin
			fail_count++;
			$display("back_to_back gave %0d vld pulses for %0d bursts",
				vld_count - start_count, num_b2b);
		end

		random_setup(12);
		drive_beats(6);                                 // cut short, no result
		@(posedge clk);
		rst <= 1'b0;
		en  <= 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
		repeat (min_gap) @(posedge clk);                // monitor flags any vld here
		random_setup(pick(1, 16));
		send_burst("after_reset", model_score(), min_gap);
		wait_results();

		for (int b = 0; b < 4; b++)
		begin
			random_setup(0);
			pos = pick(1, num_pe - 1);
			tgt = qry;
			tgt.insert(pos, pick(0, 3));                // one inserted base
			send_burst("gap_insert", model_score(), min_gap);
		end
		wait_results();

		$display("%0d vld pulses, %0d mismatches, %0d other errors",
			vld_count, mismatch_count, stray_count + fail_count);
		if (mismatch_count == 0 && stray_count == 0 && fail_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* files.f */
+incdir+hdl
+incdir+tests
hdl/sw_pkg.sv
hdl/sw_score_stage1.sv
hdl/sw_score_stage2.sv
hdl/sw_high_score.sv
hdl/sw_pe.sv
hdl/sw_array.sv
tests/sw_tb.sv

/* Makefile */
# Verilator lint and simulation of the Smith-Waterman array
VERILATOR = verilator
VFLAGS    = --timing
TOP       = sw_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# fails unless the testbench prints its pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
